//--- testbench/merge_unit_tests.txt
# columns: test name, source 0-3, data word in hex, idle cycles before the source
# offers the word, consumer mode (every, rr, hold or rand)
single  2 a5c3 0 every
all_src 0 1001 0 every
all_src 1 2001 2 every
all_src 3 4001 0 every
all_src 2 3001 1 every
all_src 0 1002 3 every
all_src 3 4002 0 every
rr      0 1101 0 rr
rr      1 2101 0 rr
rr      2 3101 0 rr
rr      3 4101 0 rr
rr      0 1102 0 rr
rr      1 2102 0 rr
rr      2 3102 0 rr
rr      3 4102 0 rr
hold    0 1201 0 hold
hold    1 2201 0 hold
hold    2 3201 0 hold
hold    3 4201 0 hold
hold    0 1202 0 hold
hold    1 2202 0 hold
hold    2 3202 0 hold
hold    3 4202 0 hold
hold    0 1203 0 hold
hold    1 2203 0 hold
rand    0 1301 0 rand
rand    1 2301 1 rand
rand    2 3301 0 rand
rand    3 4301 2 rand
rand    0 1302 0 rand
rand    2 3302 4 rand

//--- merge_unit.f
logic/merge_cfg_pkg.sv
logic/merge_types_pkg.sv
logic/vs_skid_buf.sv
logic/rr_arbiter.sv
logic/credit_pipe.sv
logic/out_fifo.sv
logic/merge_unit.sv
testbench/merge_unit_sva.sv
testbench/merge_unit_tb.sv

//--- Bender.yml
package:
  name: merge_unit

sources:
  - logic/merge_cfg_pkg.sv
  - logic/merge_types_pkg.sv
  - logic/vs_skid_buf.sv
  - logic/rr_arbiter.sv
  - logic/credit_pipe.sv
  - logic/out_fifo.sv
  - logic/merge_unit.sv
  - target: test
    files:
      - testbench/merge_unit_sva.sv
      - testbench/merge_unit_tb.sv

//--- testbench/merge_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module merge_unit_tb
  import merge_cfg_pkg::*, merge_types_pkg::*;
();

  logic                   clk;
  logic                   rst;
  logic [num_src-1:0]     src_valid;
  in_word_t [num_src-1:0] src_data;
  logic [num_src-1:0]     src_stall;
  tag_word_t              out_data;
  logic                   out_empty;
  logic                   out_rd;

  // rows of the test file, in file order
  string    row_name[$];
  int       row_src[$];
  in_word_t row_data[$];
  int       row_gap[$];
  string    row_mode[$];

  in_word_t           src_words[num_src][$]; // words a source still has to offer
  int                 src_gaps[num_src][$];  // idle cycles ahead of each of them
  tag_word_t          exp_words[num_src][$]; // tagged words still due at the output
  logic [num_src-1:0] moving;                // offered word moves on the next edge
  int                 recent_src[$];
  string              cur_name;
  string              cur_mode;
  bit                 holding;
  bit                 stall_seen;
  logic [31:0]        lcg_state;

  merge_unit dut (
    .clk       (clk),
    .rst       (rst),
    .src_valid (src_valid),
    .src_data  (src_data),
    .src_stall (src_stall),
    .out_data  (out_data),
    .out_empty (out_empty),
    .out_rd    (out_rd)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_tag_word(string name, tag_word_t exp, tag_word_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected src %0d data %h, actual src %0d data %h",
                               name, exp.src, exp.data, act.src, act.data));
    end
  endtask

  task automatic check_empty(string name, bit exp, bit act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected out_empty %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_stall(string name, logic [num_src-1:0] exp, logic [num_src-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected src_stall %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_level(string name, level_t exp, level_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error %s: expected free space %0d, actual %0d",
                               name, exp, act));
    end
  endtask

  // a bound assertion that fails ends the run at once
  always @(negedge clk) begin
    if (dut.u_sva.fail_count != 0) begin
      report_failure("a bound assertion on the merge unit failed");
    end
  end

  task automatic load_tests();
    int       fd;
    int       code;
    string    tok;
    string    line;
    string    m;
    int       s;
    int       g;
    in_word_t d;
    fd = $fopen("testbench/merge_unit_tests.txt", "r");
    if (fd == 0) report_failure("could not open testbench/merge_unit_tests.txt");
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code == 1) begin
        if (tok.substr(0, 0) == "#") begin
          code = $fgets(line, fd); // rest of a comment line
        end else begin
          code = $fscanf(fd, "%d %h %d %s", s, d, g, m);
          if (code != 4) report_failure({"malformed line in test file for test ", tok});
          row_name.push_back(tok);
          row_src.push_back(s);
          row_data.push_back(d);
          row_gap.push_back(g);
          row_mode.push_back(m);
        end
      end
    end
    $fclose(fd);
  endtask

  // each source offers its head word and keeps it up while stalled
  task automatic drive_sources();
    logic [num_src-1:0] v;
    v = '0;
    for (int i = 0; i < num_src; i++) begin
      if (moving[i]) begin
        void'(src_words[i].pop_front());
        void'(src_gaps[i].pop_front());
      end
      if (src_words[i].size() > 0) begin
        if (src_gaps[i][0] > 0) begin
          src_gaps[i][0] = src_gaps[i][0] - 1;
        end else begin
          v[i] = 1'b1;
          src_data[i] = src_words[i][0];
        end
      end
    end
    src_valid = v;
    moving = v & ~src_stall; // src_stall is a register output and holds until the edge
    if ((v & src_stall) != '0) stall_seen = 1'b1;
  endtask

  // any num_src consecutive words must come from num_src different sources
  task automatic check_rotation();
    recent_src.push_back(out_data.src);
    if (recent_src.size() > num_src) void'(recent_src.pop_front());
    if (recent_src.size() == num_src) begin
      for (int a = 0; a < num_src - 1; a++) begin
        for (int b = a + 1; b < num_src; b++) begin
          if (recent_src[a] == recent_src[b]) begin
            report_failure($sformatf("test %s: source %0d served twice in %0d words in a row",
                                     cur_name, recent_src[a], num_src));
          end
        end
      end
    end
  endtask

  // the strobe also goes out on an empty fifo, where it must be ignored
  task automatic consume_output();
    bit        want;
    int        s;
    tag_word_t exp;
    want = 1'b1;
    if (holding) begin
      want = 1'b0;
    end else if (cur_mode == "rand") begin
      lcg_state = lcg_next(lcg_state);
      want = lcg_state[16];
    end
    out_rd = want;
    if (want && !out_empty) begin
      s = out_data.src;
      if (exp_words[s].size() == 0) begin
        report_failure($sformatf("test %s: word %h arrived from source %0d with none due",
                                 cur_name, out_data.data, s));
      end
      exp = exp_words[s].pop_front();
      check_tag_word(cur_name, exp, out_data);
      if (cur_mode == "rr") check_rotation();
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    drive_sources();
    consume_output();
  endtask

  function automatic int words_pending();
    int n;
    n = 0;
    for (int i = 0; i < num_src; i++) n += exp_words[i].size();
    return n;
  endfunction

  task automatic run_test(int first, int last);
    int        n;
    tag_word_t w;
    cur_name = row_name[first];
    cur_mode = row_mode[first];
    for (int r = first; r <= last; r++) begin
      src_words[row_src[r]].push_back(row_data[r]);
      src_gaps[row_src[r]].push_back(row_gap[r]);
      w.src = src_w'(row_src[r]);
      w.data = row_data[r];
      exp_words[row_src[r]].push_back(w);
    end
    recent_src.delete();
    stall_seen = 1'b0;
    holding = (cur_mode == "hold");
    if (holding) begin
      n = 0;
      while (dut.free_space != '0) begin
        step_cycle();
        n++;
        if (n > 500) report_failure({"test ", cur_name, ": output fifo never filled"});
      end
      // fifo stays full while nobody reads
      for (int k = 0; k < pipe_depth + 4; k++) begin
        step_cycle();
        check_level(cur_name, '0, dut.free_space);
      end
      if (!stall_seen) report_failure({"test ", cur_name, ": src_stall never rose"});
      holding = 1'b0;
    end
    n = 0;
    while (words_pending() > 0) begin
      step_cycle();
      n++;
      if (n > 500) report_failure({"test ", cur_name, ": timed out waiting for its words"});
    end
    for (int k = 0; k < pipe_depth + 4; k++) step_cycle(); // late or repeated words show here
    check_empty(cur_name, 1'b1, out_empty);
  endtask

  initial begin
    int first;
    rst = 1'b1;
    src_valid = '0;
    src_data = '0;
    out_rd = 1'b0;
    moving = '0;
    holding = 1'b0;
    stall_seen = 1'b0;
    cur_name = "reset";
    cur_mode = "every";
    lcg_state = 32'hc014;
    load_tests();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_empty("reset", 1'b1, out_empty);
    check_stall("reset", '0, src_stall);
    first = 0;
    for (int r = 1; r <= row_name.size(); r++) begin
      if (r == row_name.size() || row_name[r] != row_name[first]) begin
        run_test(first, r - 1);
        first = r;
      end
    end
    if (dut.u_sva.fail_count != 0) begin
      report_failure($sformatf("%0d assertion failures in the bound checker",
                               dut.u_sva.fail_count));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/merge_unit_sva.sv
`timescale 1ns/100ps
`default_nettype none

module merge_unit_sva
  import merge_cfg_pkg::*, merge_types_pkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input logic [num_src-1:0]     src_valid,
  input in_word_t [num_src-1:0] src_data,
  input logic [num_src-1:0]     src_stall,
  input logic                   out_rd,
  input logic                   out_empty,
  input logic                   fifo_wr,
  input logic                   fifo_full,
  input level_t                 free_space
);

  int fail_count = 0;

  // credit rule keeps the pipe from writing into a full fifo
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) fifo_wr |-> !fifo_full)
    else begin
      fail_count++;
      $error("fifo written while full");
    end

  // a strobe on an empty fifo is dropped and leaves it empty
  a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
    out_rd && out_empty && !fifo_wr |=> out_empty && free_space == level_t'(fifo_depth))
    else begin
      fail_count++;
      $error("fifo read while empty");
    end

  a_space_bound: assert property (@(posedge clk) disable iff (rst)
    free_space <= level_t'(fifo_depth))
    else begin
      fail_count++;
      $error("fifo free space above its depth");
    end

  for (genvar i = 0; i < num_src; i++) begin : g_src
    a_hold_word: assert property (@(posedge clk) disable iff (rst)
      src_valid[i] && src_stall[i] |=> src_valid[i] && $stable(src_data[i]))
      else begin
        fail_count++;
        $error("source %0d dropped or changed its word while stalled", i);
      end
  end

endmodule

bind merge_unit merge_unit_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .src_valid  (src_valid),
  .src_data   (src_data),
  .src_stall  (src_stall),
  .out_rd     (out_rd),
  .out_empty  (out_empty),
  .fifo_wr    (pipe_valid),
  .fifo_full  (fifo_full),
  .free_space (free_space)
);

`default_nettype wire

//--- logic/merge_unit.sv
`timescale 1ns/100ps
`default_nettype none

module merge_unit
  import merge_cfg_pkg::*, merge_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [num_src-1:0]     src_valid,
  input  in_word_t [num_src-1:0] src_data,
  output logic [num_src-1:0]     src_stall,
  output tag_word_t              out_data,
  output logic                   out_empty,
  input  logic                   out_rd
);

  logic [num_src-1:0]     sk_valid;
  in_word_t [num_src-1:0] sk_data;
  logic [num_src-1:0]     arb_stall;

  logic      arb_valid;
  tag_word_t arb_data;
  logic      pipe_stall;
  logic      pipe_valid;
  tag_word_t pipe_data;
  level_t    free_space;
  logic      fifo_full; // observed by the bound checker

  for (genvar i = 0; i < num_src; i++) begin : g_in
    vs_skid_buf #(
      .payload_t(in_word_t)
    ) u_skid (
      .clk      (clk),
      .rst      (rst),
      .valid_us (src_valid[i]),
      .data_us  (src_data[i]),
      .stall_us (src_stall[i]),
      .valid_ds (sk_valid[i]),
      .data_ds  (sk_data[i]),
      .stall_ds (arb_stall[i])
    );
  end

  rr_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .valid_us (sk_valid),
    .data_us  (sk_data),
    .stall_us (arb_stall),
    .valid_ds (arb_valid),
    .data_ds  (arb_data),
    .stall_ds (pipe_stall)
  );

  credit_pipe u_pipe (
    .clk        (clk),
    .rst        (rst),
    .valid_us   (arb_valid),
    .data_us    (arb_data),
    .stall_us   (pipe_stall),
    .valid_ds   (pipe_valid),
    .data_ds    (pipe_data),
    .free_space (free_space)
  );

  out_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .wr         (pipe_valid),
    .wr_data    (pipe_data),
    .rd         (out_rd),
    .rd_data    (out_data),
    .empty      (out_empty),
    .full       (fifo_full),
    .free_space (free_space)
  );

endmodule

`default_nettype wire

//--- logic/out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module out_fifo
  import merge_cfg_pkg::*, merge_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wr,
  input  tag_word_t wr_data,
  input  logic      rd,
  output tag_word_t rd_data,
  output logic      empty,
  output logic      full,
  output level_t    free_space
);

  tag_word_t         mem [fifo_depth];
  logic [addr_w-1:0] rptr;
  logic [addr_w-1:0] wptr;
  level_t            zero_cnt; // free entries
  level_t            one_cnt;  // used entries
  logic              wr_ok;
  logic              rd_ok;

  assign free_space = zero_cnt;
  assign empty = (one_cnt == '0);
  assign full = (zero_cnt == '0);

  assign wr_ok = wr & ~full;
  assign rd_ok = rd & ~empty; // strobe on an empty fifo is dropped

  assign rd_data = mem[rptr]; // head is always on the output

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rptr <= '0;
      wptr <= '0;
    end else begin
      if (wr_ok) begin
        wptr <= (wptr == addr_w'(fifo_depth - 1)) ? '0 : wptr + 1'b1;
      end
      if (rd_ok) begin
        rptr <= (rptr == addr_w'(fifo_depth - 1)) ? '0 : rptr + 1'b1;
      end
    end
  end

  // both counts move together and a read with a write in one cycle cancels out
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      zero_cnt <= level_t'(fifo_depth);
      one_cnt <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10: begin
          zero_cnt <= zero_cnt - 1'b1;
          one_cnt <= one_cnt + 1'b1;
        end
        2'b01: begin
          zero_cnt <= zero_cnt + 1'b1;
          one_cnt <= one_cnt - 1'b1;
        end
        default: begin
          zero_cnt <= zero_cnt;
          one_cnt <= one_cnt;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) mem[wptr] <= wr_data;
  end

endmodule

`default_nettype wire

//--- logic/credit_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module credit_pipe
  import merge_cfg_pkg::*, merge_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      valid_us,
  input  tag_word_t data_us,
  output logic      stall_us,
  output logic      valid_ds,
  output tag_word_t data_ds,
  input  level_t    free_space
);

  logic [pipe_depth-1:0] valid_sr;
  tag_word_t             data_sr [pipe_depth];
  level_t                inflight; // words inside the pipe
  level_t                inflight_n;
  logic                  accept;

  // only take a word when the fifo is sure to have room for it on exit
  assign stall_us = (inflight >= free_space);
  assign accept = valid_us & ~stall_us;

  assign valid_ds = valid_sr[pipe_depth-1];
  assign data_ds = data_sr[pipe_depth-1];

  always_comb begin
    case ({accept, valid_ds})
      2'b10:   inflight_n = inflight + 1'b1;
      2'b01:   inflight_n = inflight - 1'b1;
      default: inflight_n = inflight;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_sr <= '0;
      inflight <= '0;
    end else begin
      valid_sr <= {valid_sr[pipe_depth-2:0], accept};
      inflight <= inflight_n;
    end
  end

  // data shifts every cycle while the valid bits mark the live stages
  always_ff @(posedge clk) begin
    data_sr[0] <= data_us;
    for (int i = 1; i < pipe_depth; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

endmodule

`default_nettype wire

//--- logic/rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter
  import merge_cfg_pkg::*, merge_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [num_src-1:0]        valid_us,
  input  in_word_t [num_src-1:0]    data_us,
  output logic [num_src-1:0]        stall_us,
  output logic                      valid_ds,
  output tag_word_t                 data_ds,
  input  logic                      stall_ds
);

  logic [src_w-1:0]   ptr;   // source with highest priority
  logic [src_w-1:0]   idx;
  logic [src_w-1:0]   sel;   // granted source
  logic               found;
  logic [num_src-1:0] grant;

  logic      valid_s1;
  tag_word_t data_s1;
  logic      buf_stall;
  logic      hold;         // tagged stage cannot move on

  assign hold = valid_s1 & buf_stall;

  // scan from ptr for the first valid source, wrapping around
  always_comb begin
    grant = '0;
    sel = '0;
    idx = '0;
    found = 1'b0;
    for (int k = 0; k < num_src; k++) begin
      idx = ptr + src_w'(k);
      if (!found && !hold && valid_us[idx]) begin
        grant[idx] = 1'b1;
        sel = idx;
        found = 1'b1;
      end
    end
  end

  assign stall_us = valid_us & ~grant; // losers and held stage both stall

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      ptr <= '0;
    end else begin
      if (!hold) valid_s1 <= found;
      if (found) ptr <= ptr + 1'b1; // rotate by one after every grant
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      data_s1.src <= sel;
      data_s1.data <= data_us[sel];
    end
  end

  // output buffer keeps the stall into the stage a register output
  vs_skid_buf #(
    .payload_t(tag_word_t)
  ) u_out_buf (
    .clk      (clk),
    .rst      (rst),
    .valid_us (valid_s1),
    .data_us  (data_s1),
    .stall_us (buf_stall),
    .valid_ds (valid_ds),
    .data_ds  (data_ds),
    .stall_ds (stall_ds)
  );

endmodule

`default_nettype wire

//--- logic/vs_skid_buf.sv
`timescale 1ns/100ps
`default_nettype none

module vs_skid_buf #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_us,
  input  payload_t data_us,
  output logic     stall_us,
  output logic     valid_ds,
  output payload_t data_ds,
  input  logic     stall_ds
);

  logic     stall_q;   // stall_ds delayed by one cycle
  logic     tmp_valid; // overflow entry occupied
  payload_t tmp_data;
  logic     accept_us; // word taken from upstream this cycle

  assign stall_us = stall_q;
  assign accept_us = valid_us & ~stall_q;

  // a held overflow word always goes out ahead of live input
  assign valid_ds = tmp_valid | accept_us;
  assign data_ds = tmp_valid ? tmp_data : data_us;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= stall_ds;
    end
  end

  // the entry fills with a word that was accepted while downstream stalled,
  // and empties on the first cycle downstream lets go
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      tmp_valid <= 1'b0;
    end else if (tmp_valid) begin
      if (!stall_ds) tmp_valid <= 1'b0;
    end else if (accept_us && stall_ds) begin
      tmp_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!tmp_valid && accept_us && stall_ds) tmp_data <= data_us;
  end

endmodule

`default_nettype wire

//--- logic/merge_types_pkg.sv
`default_nettype none

package merge_types_pkg;

  import merge_cfg_pkg::*;

  // raw word as offered by one source
  typedef logic [data_w-1:0] in_word_t;

  // word after arbitration, tagged with the source it came from
  typedef struct packed {
    logic [src_w-1:0] src;
    in_word_t data;
  } tag_word_t;

  // fifo free space and pipe in-flight count
  typedef logic [level_w-1:0] level_t;

endpackage

`default_nettype wire

//--- logic/merge_cfg_pkg.sv
`default_nettype none

package merge_cfg_pkg;

  // source side
  localparam int num_src = 4;
  localparam int src_w = 2; // enough bits to number every source

  // payload
  localparam int data_w = 16;

  // processing pipe latency in stages
  localparam int pipe_depth = 6;

  // output queue
  localparam int fifo_depth = 8;
  localparam int addr_w = $clog2(fifo_depth);

  // free space and credits run from 0 up to fifo_depth inclusive
  localparam int level_w = $clog2(fifo_depth + 1);

endpackage

`default_nettype wire
